//--- design/memSys_defines.svh
// Cache, TLB and memory dimensions, included ahead of the RTL modules that are sized by them
`default_nettype none

`ifndef MEMSYS_DEFINES_SVH
`define MEMSYS_DEFINES_SVH

// Instruction cache geometry
`define ICACHE_LINES      16
`define ICACHE_LINE_WORDS 4

// Fully associative section TLB
`define TLB_ENTRIES 4

// Bus memory depth in 32-bit words
// Four sections of 256 words each
`define MEM_WORDS 1024

// Section base and virtual section index width
`define SECTION_BITS 12

`endif

`default_nettype wire

//--- design/memSysPkg.sv
// Shared bus and descriptor types, imported by the memory subsystem RTL and its testbench
`default_nettype none

package memSysPkg;

  // Transfer size on the shared bus
  // Encoded as log2 of the byte count, as on AHB-Lite HSIZE
  typedef enum logic [2:0]
  {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } busSizeE;

  // Low two bits of a first-level descriptor
  // Only sections translate here
  // Coarse and the unlisted fine encoding both end in an abort
  typedef enum logic [1:0]
  {
    DESC_FAULT   = 2'b00,
    DESC_COARSE  = 2'b01,
    DESC_SECTION = 2'b10
  } descTypeE;

endpackage

`default_nettype wire

//--- design/busArbiter3Way.sv
// Fixed-priority arbiter that puts the walker, data port or instruction cache on the shared bus
`timescale 1ns/1ns
`default_nettype none

module busArbiter3Way (
  input  logic               clk,
  input  logic               reset,
  input  logic               walkRequest,
  input  logic [31:0]        walkAddr,
  input  logic               dataRequest,
  input  logic [31:0]        dataAddr,
  input  logic               dataWrite,
  input  memSysPkg::busSizeE dataSize,
  input  logic [31:0]        dataWData,
  input  logic               fetchRequest,
  input  logic [31:0]        fetchAddr,
  input  logic               busReady,
  output logic               busRequest,
  output logic [31:0]        busAddr,
  output logic               busWrite,
  output memSysPkg::busSizeE busSize,
  output logic [31:0]        busWData,
  output logic               walkReady,
  output logic               dataBusReady,
  output logic               fetchReady
);
  import memSysPkg::*;

  // Bit 0 walker, bit 1 data port, bit 2 instruction cache
  logic [2:0] grant;
  logic [2:0] grantQ;
  // Transfer open from acceptance up to its ready pulse
  logic       busy;

  // Held grant while open, else walker first, then data, then fetch
  always_comb
  begin
    if (busy)
      grant = grantQ;
    else if (walkRequest)
      grant = 3'b001;
    else if (dataRequest)
      grant = 3'b010;
    else if (fetchRequest)
      grant = 3'b100;
    else
      grant = 3'b000;
  end

  assign busRequest = |(grant & {fetchRequest, dataRequest, walkRequest});

  // Walker and cache only ever issue word reads
  always_comb
  begin
    busAddr  = fetchAddr;
    busWrite = 1'b0;
    busSize  = SIZE_WORD;
    busWData = dataWData;
    if (grant[0])
      busAddr = walkAddr;
    else if (grant[1])
    begin
      busAddr  = dataAddr;
      busWrite = dataWrite;
      busSize  = dataSize;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy   <= 1'b0;
      grantQ <= 3'b000;
    end
    else if (busy)
    begin
      // Released on the ready edge, next winner picked the cycle after
      if (busReady)
        busy <= 1'b0;
    end
    else if (busRequest)
    begin
      busy   <= 1'b1;
      grantQ <= grant;
    end
  end

  // Ready goes back to the owner only
  assign walkReady    = busReady & grant[0];
  assign dataBusReady = busReady & grant[1];
  assign fetchReady   = busReady & grant[2];

  // Exactly one owner whenever the bus carries a request
  assert property (@(posedge clk) disable iff (reset) busRequest |-> $onehot(grant));

endmodule

`default_nettype wire

//--- design/instrCache.sv
// Direct-mapped instruction cache that fills whole lines over the shared bus, physical addresses
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module instrCache (
  input  logic        clk,
  input  logic        reset,
  input  logic        fetchValid,
  input  logic [31:0] fetchPc,
  input  logic        icInvalidate,
  input  logic        fetchReady,
  input  logic [31:0] busRData,
  output logic [31:0] instr,
  output logic        instrValid,
  output logic        fetchRequest,
  output logic [31:0] fetchAddr
);
  localparam int OffBits = $clog2(`ICACHE_LINE_WORDS);
  localparam int IdxBits = $clog2(`ICACHE_LINES);
  localparam int TagBits = 30 - OffBits - IdxBits;

  typedef enum logic [1:0] {stIdle, stFill, stRespond} stateE;

  stateE               state;
  logic [TagBits-1:0]  tagArr [`ICACHE_LINES];
  logic [31:0]         dataArr [`ICACHE_LINES][`ICACHE_LINE_WORDS];
  logic [`ICACHE_LINES-1:0] validArr;
  // Missed PC, held for the whole fill
  logic [31:0]         pcQ;
  logic [OffBits-1:0]  fillCount;
  logic [OffBits-1:0]  pcOff;
  logic [IdxBits-1:0]  pcIdx;
  logic [TagBits-1:0]  pcTag;
  logic [OffBits-1:0]  qOff;
  logic [IdxBits-1:0]  qIdx;
  logic [TagBits-1:0]  qTag;
  logic                hit;
  logic                lastWord;

  // Incoming PC split for lookup
  assign pcOff = fetchPc[OffBits+1:2];
  assign pcIdx = fetchPc[OffBits+IdxBits+1:OffBits+2];
  assign pcTag = fetchPc[31:OffBits+IdxBits+2];
  assign hit   = validArr[pcIdx] && (tagArr[pcIdx] == pcTag);

  // Same split of the held PC
  assign qOff = pcQ[OffBits+1:2];
  assign qIdx = pcQ[OffBits+IdxBits+1:OffBits+2];
  assign qTag = pcQ[31:OffBits+IdxBits+2];

  // Line fill walks the words from offset zero
  assign fetchAddr = {pcQ[31:OffBits+2], fillCount, 2'b00};
  assign lastWord  = fillCount == OffBits'(`ICACHE_LINE_WORDS - 1);

  always_ff @(posedge clk)
  begin
    instrValid <= 1'b0;
    if (reset)
    begin
      state        <= stIdle;
      fetchRequest <= 1'b0;
      fillCount    <= '0;
    end
    else
      case (state)
        stIdle:
          if (fetchValid && hit)
            instrValid <= 1'b1;
          else if (fetchValid)
          begin
            fillCount    <= '0;
            fetchRequest <= 1'b1;
            state        <= stFill;
          end
        stFill:
          if (fetchReady)
          begin
            // Request drops on each ready edge, reraised next cycle
            fetchRequest <= 1'b0;
            fillCount    <= fillCount + 1'b1;
            if (lastWord)
              state <= stRespond;
          end
          else if (!fetchRequest)
            fetchRequest <= 1'b1;
        default:
        begin
          instrValid <= 1'b1;
          state      <= stIdle;
        end
      endcase
  end

  // Arrays, held PC and returned word
  always_ff @(posedge clk)
  begin
    if (state == stIdle && fetchValid)
    begin
      pcQ   <= fetchPc;
      instr <= dataArr[pcIdx][pcOff];
    end
    if (state == stFill && fetchReady)
    begin
      dataArr[qIdx][fillCount] <= busRData;
      if (lastWord)
        tagArr[qIdx] <= qTag;
    end
    // Addressed word once the line is complete
    if (state == stRespond)
      instr <= dataArr[qIdx][qOff];
  end

  // Invalidate beats a line completing in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset || icInvalidate)
      validArr <= '0;
    else if (state == stFill && fetchReady && lastWord)
      validArr[qIdx] <= 1'b1;
  end

endmodule

`default_nettype wire

//--- design/tableWalker.sv
// Section-only translation unit with a small TLB, walking first-level descriptors on a miss
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module tableWalker (
  input  logic        clk,
  input  logic        reset,
  input  logic        mmuEnable,
  input  logic [31:0] tableBase,
  input  logic        tlbFlush,
  input  logic        transValid,
  input  logic [31:0] transVa,
  input  logic        walkReady,
  input  logic [31:0] busRData,
  output logic        transDone,
  output logic        transFault,
  output logic [31:0] physAddr,
  output logic        walkRequest,
  output logic [31:0] walkAddr
);
  import memSysPkg::*;

  localparam int SecBits = `SECTION_BITS;
  localparam int PtrBits = $clog2(`TLB_ENTRIES);

  logic [`TLB_ENTRIES-1:0] tlbValid;
  logic [SecBits-1:0]      tlbVTag [`TLB_ENTRIES];
  logic [SecBits-1:0]      tlbPBase [`TLB_ENTRIES];
  // Round-robin victim
  logic [PtrBits-1:0]      nextVictim;
  logic [SecBits-1:0]      vaSection;
  logic [SecBits-1:0]      hitBase;
  logic                    tlbHit;
  logic                    isSection;
  logic                    fillEntry;

  // transVa stays put for the whole access
  assign vaSection = transVa[31:32-SecBits];
  // One descriptor word per virtual section
  assign walkAddr  = tableBase + 32'({vaSection, 2'b00});
  assign isSection = descTypeE'(busRData[1:0]) == DESC_SECTION;
  assign fillEntry = walkRequest && walkReady && isSection;

  // Fully associative compare
  always_comb
  begin
    tlbHit  = 1'b0;
    hitBase = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++)
      if (tlbValid[i] && tlbVTag[i] == vaSection)
      begin
        tlbHit  = 1'b1;
        hitBase = tlbPBase[i];
      end
  end

  // walkRequest doubles as the walk-in-progress state
  always_ff @(posedge clk)
  begin
    transDone  <= 1'b0;
    transFault <= 1'b0;
    if (reset)
      walkRequest <= 1'b0;
    else if (!walkRequest && transValid)
    begin
      if (!mmuEnable || tlbHit)
        transDone <= 1'b1;
      else
        walkRequest <= 1'b1;
    end
    else if (walkRequest && walkReady)
    begin
      walkRequest <= 1'b0;
      transDone   <= isSection;
      transFault  <= !isSection;
    end
  end

  // Flat mapping with the MMU off
  always_ff @(posedge clk)
  begin
    if (!walkRequest && transValid)
      physAddr <= mmuEnable ? {hitBase, transVa[31-SecBits:0]} : transVa;
    else if (walkRequest && walkReady)
      physAddr <= {busRData[31:32-SecBits], transVa[31-SecBits:0]};
    if (fillEntry)
    begin
      tlbVTag[nextVictim]  <= vaSection;
      tlbPBase[nextVictim] <= busRData[31:32-SecBits];
    end
  end

  // Flush empties the TLB even during a fill
  always_ff @(posedge clk)
  begin
    if (reset || tlbFlush)
    begin
      tlbValid   <= '0;
      nextVictim <= '0;
    end
    else if (fillEntry)
    begin
      tlbValid[nextVictim] <= 1'b1;
      nextVictim           <= nextVictim + 1'b1;
    end
  end

  // No new walk while the memory still answers the last one
  assert property (@(posedge clk) disable iff (reset) walkReady |-> !$rose(walkRequest));

endmodule

`default_nettype wire

//--- design/dataPort.sv
// Data access sequencer, translation first, then one bus transfer sized from the byte mask
`timescale 1ns/1ns
`default_nettype none

module dataPort (
  input  logic               clk,
  input  logic               reset,
  input  logic               dataValid,
  input  logic [31:0]        dataAddr,
  input  logic               dataWrite,
  input  logic [3:0]         byteMask,
  input  logic [31:0]        writeData,
  input  logic               transDone,
  input  logic               transFault,
  input  logic [31:0]        physAddr,
  input  logic               dataBusReady,
  input  logic [31:0]        busRData,
  output logic               transValid,
  output logic [31:0]        transVa,
  output logic               dataRequest,
  output logic [31:0]        dataBusAddr,
  output logic               dataBusWrite,
  output memSysPkg::busSizeE dataSize,
  output logic [31:0]        dataWData,
  output logic [31:0]        readData,
  output logic               dataReady,
  output logic               dataAbort
);
  import memSysPkg::*;

  typedef enum logic [1:0] {stIdle, stTranslate, stBus} stateE;

  stateE      state;
  logic [3:0] maskQ;
  logic [1:0] laneOffset;

  // Aligned masks only, anything else treated as a word
  always_comb
  begin
    dataSize   = SIZE_WORD;
    laneOffset = 2'd0;
    case (maskQ)
      4'b0011: dataSize = SIZE_HALF;
      4'b1100:
      begin
        dataSize   = SIZE_HALF;
        laneOffset = 2'd2;
      end
      4'b0001: dataSize = SIZE_BYTE;
      4'b0010:
      begin
        dataSize   = SIZE_BYTE;
        laneOffset = 2'd1;
      end
      4'b0100:
      begin
        dataSize   = SIZE_BYTE;
        laneOffset = 2'd2;
      end
      4'b1000:
      begin
        dataSize   = SIZE_BYTE;
        laneOffset = 2'd3;
      end
      default: dataSize = SIZE_WORD;
    endcase
  end

  always_ff @(posedge clk)
  begin
    transValid <= 1'b0;
    dataReady  <= 1'b0;
    dataAbort  <= 1'b0;
    if (reset)
    begin
      state       <= stIdle;
      dataRequest <= 1'b0;
    end
    else
      case (state)
        stIdle:
          if (dataValid)
          begin
            transValid <= 1'b1;
            state      <= stTranslate;
          end
        stTranslate:
          // Fault ends the access with no bus transfer
          if (transFault)
          begin
            dataAbort <= 1'b1;
            state     <= stIdle;
          end
          else if (transDone)
          begin
            dataRequest <= 1'b1;
            state       <= stBus;
          end
        default:
          if (dataBusReady)
          begin
            dataRequest <= 1'b0;
            dataReady   <= 1'b1;
            state       <= stIdle;
          end
      endcase
  end

  // writeData already sits in its byte lanes
  always_ff @(posedge clk)
  begin
    if (state == stIdle && dataValid)
    begin
      transVa      <= dataAddr;
      dataBusWrite <= dataWrite;
      maskQ        <= byteMask;
      dataWData    <= writeData;
    end
    if (state == stTranslate && transDone)
      dataBusAddr <= {physAddr[31:2], laneOffset};
    // Full word back, lane pick left to the core
    if (state == stBus && dataBusReady && !dataBusWrite)
      readData <= busRData;
  end

  // Core only issues naturally aligned byte, half or word masks
  assert property (@(posedge clk) disable iff (reset)
    dataValid && state == stIdle |->
      byteMask inside {4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000});

endmodule

`default_nettype wire

//--- design/busMemory.sv
// Single-cycle bus memory model with byte-lane writes, answering one cycle after each request
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module busMemory (
  input  logic               clk,
  input  logic               reset,
  input  logic               busRequest,
  input  logic [31:0]        busAddr,
  input  logic               busWrite,
  input  memSysPkg::busSizeE busSize,
  input  logic [31:0]        busWData,
  output logic               busReady,
  output logic [31:0]        busRData
);
  import memSysPkg::*;

  logic [31:0]                   mem [`MEM_WORDS];
  logic [$clog2(`MEM_WORDS)-1:0] wordIdx;
  logic [3:0]                    laneEn;
  logic                          accept;

  // Section bits 21:20 pick one of four 256-word banks
  assign wordIdx = {busAddr[21:20], busAddr[9:2]};
  // Request still high during its own ready cycle is not a new one
  assign accept  = busRequest && !busReady;

  always_comb
  begin
    case (busSize)
      SIZE_BYTE: laneEn = 4'b0001 << busAddr[1:0];
      SIZE_HALF: laneEn = busAddr[1] ? 4'b1100 : 4'b0011;
      default:   laneEn = 4'b1111;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      busReady <= 1'b0;
    else
      busReady <= accept;
  end

  // Write lands on the accepting edge, read data is the old word
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      busRData <= mem[wordIdx];
      if (busWrite)
        for (int lane = 0; lane < 4; lane++)
          if (laneEn[lane])
            mem[wordIdx][lane*8 +: 8] <= busWData[lane*8 +: 8];
    end
  end

  // Every response is a single-cycle pulse
  assert property (@(posedge clk) disable iff (reset) busReady |=> !busReady);

endmodule

`default_nettype wire

//--- design/memSysTop.sv
// Memory subsystem top, wiring the cache, walker, data port, arbiter and bus memory together
`timescale 1ns/1ns
`default_nettype none

module memSysTop (
  input  logic        clk,
  input  logic        reset,
  input  logic        fetchValid,
  input  logic [31:0] fetchPc,
  output logic [31:0] instr,
  output logic        instrValid,
  input  logic        icInvalidate,
  input  logic        dataValid,
  input  logic [31:0] dataAddr,
  input  logic        dataWrite,
  input  logic [3:0]  byteMask,
  input  logic [31:0] writeData,
  output logic [31:0] readData,
  output logic        dataReady,
  output logic        dataAbort,
  input  logic        mmuEnable,
  input  logic [31:0] tableBase,
  input  logic        tlbFlush
);
  import memSysPkg::*;

  // Peer request sets
  logic        walkRequest, walkReady;
  logic [31:0] walkAddr;
  logic        dataRequest, dataBusWrite, dataBusReady;
  logic [31:0] dataBusAddr, dataWData;
  busSizeE     dataSize;
  logic        fetchRequest, fetchReady;
  logic [31:0] fetchAddr;

  // Shared bus
  logic        busRequest, busWrite, busReady;
  logic [31:0] busAddr, busWData, busRData;
  busSizeE     busSize;

  // Data port to walker
  logic        transValid, transDone, transFault;
  logic [31:0] transVa, physAddr;

  // Core-side dataAddr and dataWrite also exist, so the bus-side pair is renamed here
  busArbiter3Way i_arbiter (
    .dataAddr (dataBusAddr),
    .dataWrite(dataBusWrite),
    .*
  );

  instrCache i_instrCache (.*);

  tableWalker i_tableWalker (.*);

  dataPort i_dataPort (.*);

  busMemory i_busMemory (.*);

endmodule

`default_nettype wire

//--- dv/memSysChecker.sv
// Testbench checker that watches the memory subsystem ports against reference models and counts errors
`timescale 1ns/1ns
`include "memSys_defines.svh"
`default_nettype none

module memSysChecker (
  input  logic        clk,
  input  logic        reset,
  input  logic        fetchValid,
  input  logic [31:0] fetchPc,
  input  logic [31:0] instr,
  input  logic        instrValid,
  input  logic        icInvalidate,
  input  logic        dataValid,
  input  logic [31:0] dataAddr,
  input  logic        dataWrite,
  input  logic [3:0]  byteMask,
  input  logic [31:0] writeData,
  input  logic [31:0] readData,
  input  logic        dataReady,
  input  logic        dataAbort,
  input  logic        mmuEnable,
  input  logic [31:0] tableBase,
  input  logic        tlbFlush,
  output int          errorCount
);
  import memSysPkg::*;

  localparam int SecBits = `SECTION_BITS;
  localparam int OffBits = $clog2(`ICACHE_LINE_WORDS);
  localparam int IdxBits = $clog2(`ICACHE_LINES);
  localparam int TagBits = 30 - OffBits - IdxBits;

  // Reference memory image, written only when a write completes
  logic [31:0]              refMem [`MEM_WORDS];
  // Section TLB model, round-robin like the walker
  logic [`TLB_ENTRIES-1:0]  tlbValid;
  logic [SecBits-1:0]       tlbVTag [`TLB_ENTRIES];
  logic [SecBits-1:0]       tlbPBase [`TLB_ENTRIES];
  int                       victim;
  // Direct-mapped cache model holding the words seen at fill time
  logic [`ICACHE_LINES-1:0] lineValid;
  logic [TagBits-1:0]       lineTag [`ICACHE_LINES];
  logic [31:0]              lineData [`ICACHE_LINES][`ICACHE_LINE_WORDS];
  // Open data access
  logic                     dataOpen;
  logic                     expAbort;
  logic                     expWrite;
  logic [31:0]              expVa;
  logic [31:0]              expPa;
  logic [3:0]               expMask;
  logic [31:0]              expWData;
  // Open fetch
  logic                     fetchOpen;
  logic [31:0]              expPc;
  logic [31:0]              expInstr;

  // Bank from bits 21:20, word within the bank from bits 9:2
  function automatic int memIndex(input logic [31:0] pa);
    return {pa[21:20], pa[9:2]};
  endfunction

  // Flat with the MMU off, else TLB then descriptor in memory
  task automatic translateAddress(input logic [31:0] va, output logic [31:0] pa,
                                  output logic fault);
    logic [SecBits-1:0] sec;
    logic [31:0]        desc;
    logic               hit;
    sec   = va[31:32-SecBits];
    pa    = va;
    fault = 1'b0;
    hit   = 1'b0;
    if (mmuEnable)
    begin
      for (int i = 0; i < `TLB_ENTRIES; i++)
        if (tlbValid[i] && tlbVTag[i] == sec)
        begin
          hit = 1'b1;
          pa  = {tlbPBase[i], va[31-SecBits:0]};
        end
      if (!hit)
      begin
        desc = refMem[memIndex(tableBase + 4 * sec)];
        if (desc[1:0] == DESC_SECTION)
        begin
          pa               = {desc[31:32-SecBits], va[31-SecBits:0]};
          tlbVTag[victim]  = sec;
          tlbPBase[victim] = desc[31:32-SecBits];
          tlbValid[victim] = 1'b1;
          victim           = (victim + 1) % `TLB_ENTRIES;
        end
        else
          fault = 1'b1;
      end
    end
  endtask

  // Lookup, filling the whole line from the image on a miss
  task automatic predictFetch(input logic [31:0] pc);
    logic [IdxBits-1:0] idx;
    logic [TagBits-1:0] tag;
    logic [31:0]        lineBase;
    idx      = pc[OffBits+IdxBits+1:OffBits+2];
    tag      = pc[31:OffBits+IdxBits+2];
    lineBase = {pc[31:OffBits+2], {(OffBits + 2){1'b0}}};
    if (!(lineValid[idx] && lineTag[idx] == tag))
    begin
      for (int w = 0; w < `ICACHE_LINE_WORDS; w++)
        lineData[idx][w] = refMem[memIndex(lineBase + 4 * w)];
      lineTag[idx]   = tag;
      lineValid[idx] = 1'b1;
    end
    expInstr = lineData[idx][pc[OffBits+1:2]];
  endtask

  // Sampled mid-cycle, away from both edges
  always @(negedge clk)
  begin
    if (reset)
    begin
      errorCount = 0;
      dataOpen   = 1'b0;
      fetchOpen  = 1'b0;
      tlbValid   = '0;
      victim     = 0;
      lineValid  = '0;
    end
    else
    begin
      // Completion first, a new access may start in the same cycle
      if (dataReady || dataAbort)
      begin
        if (!dataOpen)
        begin
          $display("%0t: data completion pulse seen with no access open", $time);
          errorCount++;
        end
        else if (dataAbort != expAbort)
        begin
          $display("ERR %0t: access to va %h %s, expected %s", $time, expVa,
                   dataAbort ? "aborted" : "completed", expAbort ? "abort" : "completion");
          errorCount++;
        end
        else if (dataReady && expWrite)
        begin
          for (int lane = 0; lane < 4; lane++)
            if (expMask[lane])
              refMem[memIndex(expPa)][lane*8 +: 8] = expWData[lane*8 +: 8];
        end
        else if (dataReady && readData !== refMem[memIndex(expPa)])
        begin
          $display("ERR %0t: read va %h pa %h returned %h, expected %h", $time, expVa,
                   expPa, readData, refMem[memIndex(expPa)]);
          errorCount++;
        end
        dataOpen = 1'b0;
      end
      if (instrValid)
      begin
        if (!fetchOpen)
        begin
          $display("%0t: instruction pulse seen with no fetch open", $time);
          errorCount++;
        end
        else if (instr !== expInstr)
        begin
          $display("ERR %0t: fetch at %h returned %h, expected %h", $time, expPc, instr,
                   expInstr);
          errorCount++;
        end
        fetchOpen = 1'b0;
      end
      if (tlbFlush)
      begin
        tlbValid = '0;
        victim   = 0;
      end
      if (icInvalidate)
        lineValid = '0;
      if (dataValid && !dataOpen)
      begin
        dataOpen = 1'b1;
        expVa    = dataAddr;
        expWrite = dataWrite;
        expMask  = byteMask;
        expWData = writeData;
        translateAddress(dataAddr, expPa, expAbort);
      end
      if (fetchValid && !fetchOpen)
      begin
        fetchOpen = 1'b1;
        expPc     = fetchPc;
        predictFetch(fetchPc);
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/memSysTb.sv
// Testbench top for the memory subsystem, runs a table of data accesses and fetches on the DUT
`timescale 1ns/1ns
`default_nettype none

module memSysTb;
  import memSysPkg::*;

  localparam int TimeoutCycles = 200;

  typedef enum logic [2:0] {opWrite, opRead, opDesc, opFetch, opInval, opFlush, opDual} opKindE;

  // Dual rows read at addr and fetch from the desc column
  typedef struct packed {
    opKindE      kind;
    logic [31:0] addr;
    logic [3:0]  mask;
    logic        mmu;
    logic [31:0] desc;
  } rowT;

  logic        clk;
  logic        reset;
  logic        fetchValid;
  logic [31:0] fetchPc;
  logic [31:0] instr;
  logic        instrValid;
  logic        icInvalidate;
  logic        dataValid;
  logic [31:0] dataAddr;
  logic        dataWrite;
  logic [3:0]  byteMask;
  logic [31:0] writeData;
  logic [31:0] readData;
  logic        dataReady;
  logic        dataAbort;
  logic        mmuEnable;
  logic [31:0] tableBase;
  logic        tlbFlush;
  logic [15:0] lfsr;
  int          checkerErrors;
  int          timeoutCount;
  int          rowIdx;
  rowT         stimTable [$];

  memSysTop i_dut (.*);

  memSysChecker i_checker (.errorCount(checkerErrors), .*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 16, 14, 13, 11, shifting right
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[0] ^ state[2] ^ state[3] ^ state[5], state[15:1]};
  endfunction

  task automatic randomWord(output logic [31:0] word);
    word = '0;
    for (int b = 0; b < 32; b++)
    begin
      word = {word[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  task automatic finishRun();
    $display("Errors: %0d from checker, %0d timeouts", checkerErrors, timeoutCount);
    if (checkerErrors == 0 && timeoutCount == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  // Completion pulses are one cycle wide, so look once per cycle
  task automatic waitDone(input logic needFetch, input logic needData);
    int   cycles;
    logic fetchSeen;
    logic dataSeen;
    cycles    = 0;
    fetchSeen = !needFetch || instrValid;
    dataSeen  = !needData || dataReady || dataAbort;
    while (!(fetchSeen && dataSeen) && cycles < TimeoutCycles)
    begin
      @(posedge clk);
      #1;
      cycles++;
      fetchSeen = fetchSeen || instrValid;
      dataSeen  = dataSeen || dataReady || dataAbort;
    end
    if (!(fetchSeen && dataSeen))
    begin
      $display("Timeout at %0t, no %s completion within %0d cycles", $time,
               fetchSeen ? "data" : "fetch", TimeoutCycles);
      timeoutCount++;
    end
  endtask

  task automatic addRow(input opKindE kind, input logic [31:0] addr, input logic [3:0] mask,
                        input logic mmu, input logic [31:0] desc);
    stimTable.push_back('{kind, addr, mask, mmu, desc});
  endtask

  task automatic runRow(input rowT row);
    logic [31:0] word;
    word = row.desc;
    if (row.kind == opWrite)
      randomWord(word);
    case (row.kind)
      opWrite, opRead, opDesc, opDual:
      begin
        mmuEnable = row.mmu;
        dataValid = 1'b1;
        dataAddr  = row.addr;
        dataWrite = row.kind == opWrite || row.kind == opDesc;
        byteMask  = row.mask;
        writeData = word;
        if (row.kind == opDual)
        begin
          fetchValid = 1'b1;
          fetchPc    = row.desc;
        end
        @(posedge clk);
        #1;
        dataValid  = 1'b0;
        fetchValid = 1'b0;
        waitDone(row.kind == opDual, 1'b1);
      end
      opFetch:
      begin
        fetchValid = 1'b1;
        fetchPc    = row.addr;
        @(posedge clk);
        #1;
        fetchValid = 1'b0;
        waitDone(1'b1, 1'b0);
      end
      opInval:
      begin
        icInvalidate = 1'b1;
        @(posedge clk);
        #1;
        icInvalidate = 1'b0;
      end
      default:
      begin
        tlbFlush = 1'b1;
        @(posedge clk);
        #1;
        tlbFlush = 1'b0;
      end
    endcase
    // Quiet cycle between rows
    @(posedge clk);
    #1;
  endtask

  task automatic buildTable();
    // Lane merges with the MMU off
    addRow(opWrite, 32'h0000_0100, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0100, 4'b0011, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0100, 4'b0100, 1'b0, 32'h0);
    addRow(opRead,  32'h0000_0100, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0104, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0104, 4'b1100, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0104, 4'b0010, 1'b0, 32'h0);
    addRow(opRead,  32'h0000_0104, 4'b1111, 1'b0, 32'h0);
    // Sections 0x10 and 0x11 alias, 0x12 fault, 0x13 coarse
    addRow(opDesc,  32'h0030_0040, 4'b1111, 1'b0, 32'h0010_0002);
    addRow(opDesc,  32'h0030_0044, 4'b1111, 1'b0, 32'h0010_0002);
    addRow(opDesc,  32'h0030_0048, 4'b1111, 1'b0, 32'h0000_0000);
    addRow(opDesc,  32'h0030_004C, 4'b1111, 1'b0, 32'h0020_0001);
    addRow(opDesc,  32'h0030_0050, 4'b1111, 1'b0, 32'h0010_0002);
    addRow(opWrite, 32'h0100_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opWrite, 32'h0100_0204, 4'b0011, 1'b1, 32'h0);
    addRow(opRead,  32'h0110_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opRead,  32'h0110_0204, 4'b1111, 1'b1, 32'h0);
    // Word 0 is where a faulted write would land if it leaked onto the bus
    addRow(opWrite, 32'h0000_0000, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0120_0000, 4'b1111, 1'b1, 32'h0);
    addRow(opRead,  32'h0130_0000, 4'b1111, 1'b1, 32'h0);
    addRow(opRead,  32'h0000_0000, 4'b1111, 1'b0, 32'h0);
    // Section 0x14 moves, cached mapping holds until the flush
    addRow(opRead,  32'h0140_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opDesc,  32'h0030_0050, 4'b1111, 1'b0, 32'h0020_0002);
    addRow(opWrite, 32'h0140_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opRead,  32'h0100_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opFlush, 32'h0,         4'b0000, 1'b0, 32'h0);
    addRow(opWrite, 32'h0140_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opRead,  32'h0140_0200, 4'b1111, 1'b1, 32'h0);
    addRow(opRead,  32'h0020_0200, 4'b1111, 1'b0, 32'h0);
    addRow(opRead,  32'h0010_0200, 4'b1111, 1'b0, 32'h0);
    // Fetch line, stale word until invalidate
    addRow(opWrite, 32'h0000_0300, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0304, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0308, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_030C, 4'b1111, 1'b0, 32'h0);
    addRow(opFetch, 32'h0000_0300, 4'b0000, 1'b0, 32'h0);
    addRow(opFetch, 32'h0000_0308, 4'b0000, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0308, 4'b1111, 1'b0, 32'h0);
    addRow(opFetch, 32'h0000_0308, 4'b0000, 1'b0, 32'h0);
    addRow(opInval, 32'h0,         4'b0000, 1'b0, 32'h0);
    addRow(opFetch, 32'h0000_0308, 4'b0000, 1'b0, 32'h0);
    // Fetch and data started together
    addRow(opWrite, 32'h0000_0400, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0404, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0408, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_040C, 4'b1111, 1'b0, 32'h0);
    addRow(opWrite, 32'h0000_0500, 4'b1111, 1'b0, 32'h0);
    addRow(opDual,  32'h0000_0500, 4'b1111, 1'b0, 32'h0000_0404);
    addRow(opDual,  32'h0100_0200, 4'b1111, 1'b1, 32'h0000_040C);
  endtask

  initial
  begin
    reset        = 1'b1;
    fetchValid   = 1'b0;
    fetchPc      = '0;
    icInvalidate = 1'b0;
    dataValid    = 1'b0;
    dataAddr     = '0;
    dataWrite    = 1'b0;
    byteMask     = 4'b1111;
    writeData    = '0;
    mmuEnable    = 1'b0;
    tableBase    = 32'h0030_0000;
    tlbFlush     = 1'b0;
    lfsr         = 16'd62;
    timeoutCount = 0;
    buildTable();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    // A timeout stops the table, the run then ends on the closing report
    rowIdx = 0;
    while (rowIdx < stimTable.size() && timeoutCount == 0)
    begin
      runRow(stimTable[rowIdx]);
      rowIdx++;
    end
    finishRun();
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/memSysPkg.sv
design/busArbiter3Way.sv
design/instrCache.sv
design/tableWalker.sv
design/dataPort.sv
design/busMemory.sv
design/memSysTop.sv
dv/memSysChecker.sv
dv/memSysTb.sv

//--- Bender.yml
package:
  name: mem_sys

export_include_dirs:
  - design

sources:
  - files:
      - design/memSysPkg.sv
      - design/busArbiter3Way.sv
      - design/instrCache.sv
      - design/tableWalker.sv
      - design/dataPort.sv
      - design/busMemory.sv
      - design/memSysTop.sv
  - target: test
    files:
      - dv/memSysChecker.sv
      - dv/memSysTb.sv
